//--- verilog/id_defs.svh
////////////////////
// Datapath widths and RV32I instruction field positions
////////////////////
`ifndef ID_DEFS_SVH
`define ID_DEFS_SVH

// Datapath and register file geometry
`define XLEN          32
`define NUM_REGS      32
`define REG_ADDR_W    5

// Register index fields
`define REG_RS1       19:15
`define REG_RS2       24:20
`define REG_RD        11:7

// Opcode and function fields
`define INSTR_OPCODE  6:0
`define INSTR_FUNCT3  14:12
`define INSTR_FUNCT7  31:25

`endif

//--- verilog/id_pkg.sv
////////////////////
// Decode stage enums and packed bundles
////////////////////
`include "id_defs.svh"

package id_pkg;

  // Major opcodes handled by the decoder
  typedef enum logic [6:0] {
    OPC_LUI    = 7'h37,
    OPC_AUIPC  = 7'h17,
    OPC_JAL    = 7'h6f,
    OPC_BRANCH = 7'h63,
    OPC_LOAD   = 7'h03,
    OPC_STORE  = 7'h23,
    OPC_OP_IMM = 7'h13,
    OPC_OP     = 7'h33
  } opcode_e;

  // ALU operations, compares last before NOP
  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_AND, ALU_OR, ALU_XOR,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU,
    ALU_NOP
  } alu_op_e;

  typedef enum logic [1:0] {OP_A_REG, OP_A_PC, OP_A_ZERO} op_a_sel_e;
  typedef enum logic       {OP_B_REG, OP_B_IMM} op_b_sel_e;
  typedef enum logic [1:0] {IMM_I, IMM_S, IMM_U, IMM_PCINCR} imm_sel_e;
  typedef enum logic [1:0] {SEL_REGFILE, SEL_FW_EX, SEL_FW_WB} fw_sel_e;
  typedef enum logic [1:0] {JUMP_NONE, JUMP_JAL, JUMP_BRANCH} jump_e;
  typedef enum logic [1:0] {CTRL_IDLE, CTRL_FIRST_FETCH, CTRL_DECODE} ctrl_state_e;

  // Register write, also used as a forwarding source
  typedef struct packed {
    logic                   we;
    logic [`REG_ADDR_W-1:0] waddr;
    logic [`XLEN-1:0]       wdata;
  } rf_wr_t;

  // Decoder output
  typedef struct packed {
    alu_op_e    alu_op;
    op_a_sel_e  op_a_sel;
    op_b_sel_e  op_b_sel;
    imm_sel_e   imm_sel;
    logic       rs1_used;
    logic       rs2_used;
    logic       regfile_we;
    logic       data_req;
    logic       data_we;
    logic [1:0] data_type;
    logic       data_sign_ext;
    jump_e      jump;
    logic       illegal;
  } dec_ctrl_t;

  // ID/EX pipeline contents
  typedef struct packed {
    alu_op_e                alu_op;
    logic [`XLEN-1:0]       operand_a;
    logic [`XLEN-1:0]       operand_b;
    logic [`REG_ADDR_W-1:0] regfile_waddr;
    logic                   regfile_we;
    logic                   data_req;
    logic                   data_we;
    logic [1:0]             data_type;
    logic                   data_sign_ext;
    jump_e                  jump;
  } id_ex_t;

endpackage

//--- verilog/id_decoder.sv
////////////////////
// Combinational RV32I subset decoder
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_decoder
(
  input  logic [`XLEN-1:0]  instr_i,
  output id_pkg::dec_ctrl_t ctrl_o
);

  import id_pkg::*;

  opcode_e    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  dec_ctrl_t  ctrl;

  assign opcode = opcode_e'(instr_i[`INSTR_OPCODE]);
  assign funct3 = instr_i[`INSTR_FUNCT3];
  assign funct7 = instr_i[`INSTR_FUNCT7];

  always_comb
  begin
    // Defaults, nothing written and nothing accessed
    ctrl.alu_op        = ALU_NOP;
    ctrl.op_a_sel      = OP_A_REG;
    ctrl.op_b_sel      = OP_B_REG;
    ctrl.imm_sel       = IMM_I;
    ctrl.rs1_used      = 1'b0;
    ctrl.rs2_used      = 1'b0;
    ctrl.regfile_we    = 1'b0;
    ctrl.data_req      = 1'b0;
    ctrl.data_we       = 1'b0;
    ctrl.data_type     = funct3[1:0];
    ctrl.data_sign_ext = ~funct3[2];
    ctrl.jump          = JUMP_NONE;
    ctrl.illegal       = 1'b0;

    case (opcode)
      // Upper immediates, operand A is zero or PC
      OPC_LUI, OPC_AUIPC:
      begin
        ctrl.alu_op     = ALU_ADD;
        ctrl.op_a_sel   = (opcode == OPC_LUI) ? OP_A_ZERO : OP_A_PC;
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.imm_sel    = IMM_U;
        ctrl.regfile_we = 1'b1;
      end
      // Link value is PC + 4
      OPC_JAL:
      begin
        ctrl.alu_op     = ALU_ADD;
        ctrl.op_a_sel   = OP_A_PC;
        ctrl.op_b_sel   = OP_B_IMM;
        ctrl.imm_sel    = IMM_PCINCR;
        ctrl.regfile_we = 1'b1;
        ctrl.jump       = JUMP_JAL;
      end
      OPC_BRANCH:
      begin
        ctrl.rs1_used = 1'b1;
        ctrl.rs2_used = 1'b1;
        ctrl.jump     = JUMP_BRANCH;
        case (funct3)
          3'b000:  ctrl.alu_op = ALU_EQ;
          3'b001:  ctrl.alu_op = ALU_NE;
          3'b100:  ctrl.alu_op = ALU_LT;
          3'b101:  ctrl.alu_op = ALU_GE;
          3'b110:  ctrl.alu_op = ALU_LTU;
          3'b111:  ctrl.alu_op = ALU_GEU;
          default: ctrl.illegal = 1'b1;
        endcase
      end
      // Address is rs1 + I or S immediate
      OPC_LOAD, OPC_STORE:
      begin
        ctrl.alu_op   = ALU_ADD;
        ctrl.op_b_sel = OP_B_IMM;
        ctrl.rs1_used = 1'b1;
        ctrl.data_req = 1'b1;
        if (opcode == OPC_LOAD)
        begin
          ctrl.regfile_we = 1'b1;
          // LB LH LW LBU LHU only
          ctrl.illegal    = (funct3[1:0] == 2'b11) || (funct3[2] && funct3[1]);
        end
        else
        begin
          ctrl.imm_sel  = IMM_S;
          ctrl.rs2_used = 1'b1;
          ctrl.data_we  = 1'b1;
          ctrl.illegal  = funct3[2] || (funct3[1:0] == 2'b11);
        end
      end
      // Register-register and register-immediate ALU ops
      OPC_OP, OPC_OP_IMM:
      begin
        ctrl.rs1_used   = 1'b1;
        ctrl.rs2_used   = (opcode == OPC_OP);
        ctrl.op_b_sel   = (opcode == OPC_OP) ? OP_B_REG : OP_B_IMM;
        ctrl.regfile_we = 1'b1;
        case (funct3)
          3'b000:  ctrl.alu_op = (opcode == OPC_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001:  ctrl.alu_op = ALU_SLL;
          3'b010:  ctrl.alu_op = ALU_SLT;
          3'b011:  ctrl.alu_op = ALU_SLTU;
          3'b100:  ctrl.alu_op = ALU_XOR;
          3'b101:  ctrl.alu_op = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110:  ctrl.alu_op = ALU_OR;
          default: ctrl.alu_op = ALU_AND;
        endcase
        // Non-shift OP-IMM carries immediate bits in funct7
        if (opcode == OPC_OP_IMM && funct3 != 3'b001 && funct3 != 3'b101)
          ctrl.illegal = 1'b0;
        // Otherwise funct7 must be zero, bit 5 allowed for SUB, SRA and SRAI
        else if ((funct7 & 7'b1011111) != 7'd0)
          ctrl.illegal = 1'b1;
        else if (funct7[5] && (funct3 != 3'b101) && !(opcode == OPC_OP && funct3 == 3'b000))
          ctrl.illegal = 1'b1;
      end
      default: ctrl.illegal = 1'b1;
    endcase

    // Unknown encodings never write, access memory or jump
    if (ctrl.illegal)
    begin
      ctrl.regfile_we = 1'b0;
      ctrl.data_req   = 1'b0;
      ctrl.jump       = JUMP_NONE;
    end
  end

  assign ctrl_o = ctrl;

endmodule

//--- verilog/id_controller.sv
////////////////////
// Start-up FSM, load-use hazard and forwarding selects
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_controller
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   fetch_enable_i,
  input  id_pkg::dec_ctrl_t      ctrl_i,
  input  logic [`REG_ADDR_W-1:0] rs1_i,
  input  logic [`REG_ADDR_W-1:0] rs2_i,
  input  id_pkg::id_ex_t         id_ex_i,
  input  id_pkg::rf_wr_t         ex_fw_i,
  input  id_pkg::rf_wr_t         wb_wr_i,
  output logic                   instr_req_o,
  output logic                   is_decoding_o,
  output logic                   load_stall_o,
  output id_pkg::fw_sel_e        fw_a_sel_o,
  output id_pkg::fw_sel_e        fw_b_sel_o
);

  import id_pkg::*;

  ctrl_state_e state_q;
  ctrl_state_e state_d;
  logic        ex_is_load;

  // EX wins over WB, x0 never forwards
  function automatic fw_sel_e pick_fw(input logic [`REG_ADDR_W-1:0] rs,
                                      input rf_wr_t ex,
                                      input rf_wr_t wb);
    fw_sel_e sel;
    sel = SEL_REGFILE;
    if (rs != '0)
    begin
      if (ex.we && (ex.waddr == rs))
        sel = SEL_FW_EX;
      else if (wb.we && (wb.waddr == rs))
        sel = SEL_FW_WB;
    end
    return sel;
  endfunction

  ////////////////////
  // Start-up FSM
  ////////////////////
  always_comb
  begin
    state_d = state_q;
    case (state_q)
      CTRL_IDLE:        if (fetch_enable_i) state_d = CTRL_FIRST_FETCH;
      CTRL_FIRST_FETCH: state_d = CTRL_DECODE;
      CTRL_DECODE:      if (!fetch_enable_i) state_d = CTRL_IDLE;
      default:          state_d = CTRL_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
      state_q <= CTRL_IDLE;
    else
      state_q <= state_d;
  end

  // Fetch runs from the first fetch on, decode one cycle later
  assign instr_req_o   = (state_q == CTRL_FIRST_FETCH) || (state_q == CTRL_DECODE);
  assign is_decoding_o = (state_q == CTRL_DECODE);

  ////////////////////
  // Hazards
  ////////////////////
  // Load in EX whose result is not yet available
  assign ex_is_load = id_ex_i.data_req && !id_ex_i.data_we && id_ex_i.regfile_we &&
                      (id_ex_i.regfile_waddr != '0);

  assign load_stall_o = ex_is_load &&
                        ((ctrl_i.rs1_used && (id_ex_i.regfile_waddr == rs1_i)) ||
                         (ctrl_i.rs2_used && (id_ex_i.regfile_waddr == rs2_i)));

  assign fw_a_sel_o = pick_fw(rs1_i, ex_fw_i, wb_wr_i);
  assign fw_b_sel_o = pick_fw(rs2_i, ex_fw_i, wb_wr_i);

endmodule

//--- verilog/id_register_file.sv
////////////////////
// 32x32 register file, two reads and one write
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_register_file
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`REG_ADDR_W-1:0] raddr_a_i,
  input  logic [`REG_ADDR_W-1:0] raddr_b_i,
  output logic [`XLEN-1:0]       rdata_a_o,
  output logic [`XLEN-1:0]       rdata_b_o,
  input  id_pkg::rf_wr_t         wr_i
);

  logic [`XLEN-1:0] regs [`NUM_REGS];

  // Write at the edge, x0 stays zero
  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      for (int i = 0; i < `NUM_REGS; i++)
        regs[i] <= '0;
    end
    else if (wr_i.we && (wr_i.waddr != '0))
    begin
      regs[wr_i.waddr] <= wr_i.wdata;
    end
  end

  // Asynchronous reads
  assign rdata_a_o = (raddr_a_i == '0) ? '0 : regs[raddr_a_i];
  assign rdata_b_o = (raddr_b_i == '0) ? '0 : regs[raddr_b_i];

endmodule

//--- verilog/id_operand_path.sv
////////////////////
// Immediates, forwarding and operand muxes, jump target
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_operand_path
(
  input  logic [`XLEN-1:0] instr_i,
  input  logic [`XLEN-1:0] pc_id_i,
  input  id_pkg::dec_ctrl_t ctrl_i,
  input  id_pkg::fw_sel_e   fw_a_sel_i,
  input  id_pkg::fw_sel_e   fw_b_sel_i,
  input  logic [`XLEN-1:0] rdata_a_i,
  input  logic [`XLEN-1:0] rdata_b_i,
  input  id_pkg::rf_wr_t    ex_fw_i,
  input  id_pkg::rf_wr_t    wb_wr_i,
  output logic [`XLEN-1:0] operand_a_o,
  output logic [`XLEN-1:0] operand_b_o,
  output logic [`XLEN-1:0] jump_target_o
);

  import id_pkg::*;

  logic [`XLEN-1:0] imm_i;
  logic [`XLEN-1:0] imm_s;
  logic [`XLEN-1:0] imm_sb;
  logic [`XLEN-1:0] imm_u;
  logic [`XLEN-1:0] imm_uj;
  logic [`XLEN-1:0] imm_b;
  logic [`XLEN-1:0] fw_a;
  logic [`XLEN-1:0] fw_b;

  // Register file value or a forwarded result
  function automatic logic [`XLEN-1:0] fw_mux(input fw_sel_e sel,
                                              input logic [`XLEN-1:0] rf,
                                              input logic [`XLEN-1:0] ex,
                                              input logic [`XLEN-1:0] wb);
    case (sel)
      SEL_FW_EX: return ex;
      SEL_FW_WB: return wb;
      default:   return rf;
    endcase
  endfunction

  ////////////////////
  // Immediates
  ////////////////////
  assign imm_i  = {{20{instr_i[31]}}, instr_i[31:20]};
  assign imm_s  = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
  assign imm_sb = {{19{instr_i[31]}}, instr_i[31], instr_i[7], instr_i[30:25],
                   instr_i[11:8], 1'b0};
  assign imm_u  = {instr_i[31:12], 12'b0};
  assign imm_uj = {{12{instr_i[31]}}, instr_i[19:12], instr_i[20], instr_i[30:21], 1'b0};

  always_comb
  begin
    case (ctrl_i.imm_sel)
      IMM_S:      imm_b = imm_s;
      IMM_U:      imm_b = imm_u;
      IMM_PCINCR: imm_b = `XLEN'd4;
      default:    imm_b = imm_i;
    endcase
  end

  ////////////////////
  // Operands
  ////////////////////
  assign fw_a = fw_mux(fw_a_sel_i, rdata_a_i, ex_fw_i.wdata, wb_wr_i.wdata);
  assign fw_b = fw_mux(fw_b_sel_i, rdata_b_i, ex_fw_i.wdata, wb_wr_i.wdata);

  always_comb
  begin
    case (ctrl_i.op_a_sel)
      OP_A_PC:   operand_a_o = pc_id_i;
      OP_A_ZERO: operand_a_o = '0;
      default:   operand_a_o = fw_a;
    endcase
  end

  assign operand_b_o = (ctrl_i.op_b_sel == OP_B_IMM) ? imm_b : fw_b;

  // JAL uses the UJ offset, branches the SB offset
  assign jump_target_o = pc_id_i + ((ctrl_i.jump == JUMP_JAL) ? imm_uj : imm_sb);

endmodule

//--- verilog/id_ex_pipe.sv
////////////////////
// ID/EX register with bubble and hold
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_ex_pipe
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   id_valid_i,
  input  logic                   ex_ready_i,
  input  id_pkg::dec_ctrl_t      ctrl_i,
  input  logic [`XLEN-1:0]       operand_a_i,
  input  logic [`XLEN-1:0]       operand_b_i,
  input  logic [`REG_ADDR_W-1:0] rd_i,
  output id_pkg::id_ex_t         id_ex_o
);

  import id_pkg::*;

  always_ff @(posedge clk, negedge rst_n)
  begin
    if (!rst_n)
    begin
      id_ex_o        <= '0;
      id_ex_o.alu_op <= ALU_NOP;
      id_ex_o.jump   <= JUMP_NONE;
    end
    else if (id_valid_i)
    begin
      // New instruction enters EX
      id_ex_o.alu_op        <= ctrl_i.alu_op;
      id_ex_o.operand_a     <= operand_a_i;
      id_ex_o.operand_b     <= operand_b_i;
      id_ex_o.regfile_waddr <= rd_i;
      id_ex_o.regfile_we    <= ctrl_i.regfile_we;
      id_ex_o.data_req      <= ctrl_i.data_req;
      id_ex_o.data_we       <= ctrl_i.data_we;
      id_ex_o.data_type     <= ctrl_i.data_type;
      id_ex_o.data_sign_ext <= ctrl_i.data_sign_ext;
      id_ex_o.jump          <= ctrl_i.jump;
    end
    else if (ex_ready_i)
    begin
      // Bubble, side effects off, payload kept
      id_ex_o.regfile_we <= 1'b0;
      id_ex_o.data_req   <= 1'b0;
      id_ex_o.data_we    <= 1'b0;
      id_ex_o.jump       <= JUMP_NONE;
    end
  end

endmodule

//--- verilog/id_stage.sv
////////////////////
// Decode stage top level
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_stage
(
  input  logic             clk,
  input  logic             rst_n,
  input  logic             fetch_enable_i,
  input  logic             if_valid_i,
  input  logic             ex_ready_i,
  input  logic [`XLEN-1:0] instr_rdata_i,
  input  logic [`XLEN-1:0] pc_id_i,
  input  id_pkg::rf_wr_t   wb_wr_i,
  input  id_pkg::rf_wr_t   ex_fw_i,
  output logic             instr_req_o,
  output logic             is_decoding_o,
  output logic             id_ready_o,
  output logic             id_valid_o,
  output logic             illegal_insn_o,
  output logic [`XLEN-1:0] jump_target_o,
  output id_pkg::id_ex_t   id_ex_o
);

  import id_pkg::*;

  logic [`REG_ADDR_W-1:0] rs1;
  logic [`REG_ADDR_W-1:0] rs2;
  logic [`REG_ADDR_W-1:0] rd;
  dec_ctrl_t              dec_ctrl;
  fw_sel_e                fw_a_sel;
  fw_sel_e                fw_b_sel;
  logic                   load_stall;
  logic [`XLEN-1:0]       rdata_a;
  logic [`XLEN-1:0]       rdata_b;
  logic [`XLEN-1:0]       operand_a;
  logic [`XLEN-1:0]       operand_b;

  // Register fields
  assign rs1 = instr_rdata_i[`REG_RS1];
  assign rs2 = instr_rdata_i[`REG_RS2];
  assign rd  = instr_rdata_i[`REG_RD];

  ////////////////////
  // Handshake
  ////////////////////
  assign id_ready_o     = !load_stall && ex_ready_i;
  assign id_valid_o     = is_decoding_o && if_valid_i && id_ready_o;
  // Only flag an illegal instruction when it is consumed
  assign illegal_insn_o = dec_ctrl.illegal && id_valid_o;

  id_decoder decoder_inst
  (
    .instr_i (instr_rdata_i),
    .ctrl_o  (dec_ctrl)
  );

  id_controller controller_inst
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .ctrl_i         (dec_ctrl),
    .rs1_i          (rs1),
    .rs2_i          (rs2),
    .id_ex_i        (id_ex_o),
    .ex_fw_i        (ex_fw_i),
    .wb_wr_i        (wb_wr_i),
    .instr_req_o    (instr_req_o),
    .is_decoding_o  (is_decoding_o),
    .load_stall_o   (load_stall),
    .fw_a_sel_o     (fw_a_sel),
    .fw_b_sel_o     (fw_b_sel)
  );

  // Written from WB only
  id_register_file register_file_inst
  (
    .clk       (clk),
    .rst_n     (rst_n),
    .raddr_a_i (rs1),
    .raddr_b_i (rs2),
    .rdata_a_o (rdata_a),
    .rdata_b_o (rdata_b),
    .wr_i      (wb_wr_i)
  );

  id_operand_path operand_path_inst
  (
    .instr_i       (instr_rdata_i),
    .pc_id_i       (pc_id_i),
    .ctrl_i        (dec_ctrl),
    .fw_a_sel_i    (fw_a_sel),
    .fw_b_sel_i    (fw_b_sel),
    .rdata_a_i     (rdata_a),
    .rdata_b_i     (rdata_b),
    .ex_fw_i       (ex_fw_i),
    .wb_wr_i       (wb_wr_i),
    .operand_a_o   (operand_a),
    .operand_b_o   (operand_b),
    .jump_target_o (jump_target_o)
  );

  id_ex_pipe ex_pipe_inst
  (
    .clk         (clk),
    .rst_n       (rst_n),
    .id_valid_i  (id_valid_o),
    .ex_ready_i  (ex_ready_i),
    .ctrl_i      (dec_ctrl),
    .operand_a_i (operand_a),
    .operand_b_i (operand_b),
    .rd_i        (rd),
    .id_ex_o     (id_ex_o)
  );

endmodule

//--- bench/id_stage_tb.sv
////////////////////
// Decode stage testbench with reference model and result checker
////////////////////
`timescale 1ns/10ps
`include "id_defs.svh"

module id_stage_tb;

  import id_pkg::*;

  localparam int WAIT_LIMIT = 10;

  // Expected bundle, full is low when only side effects are checked
  typedef struct {
    id_ex_t bundle;
    logic   full;
  } expect_t;

  logic             clk;
  logic             rst_n;
  logic             fetch_enable_i;
  logic             if_valid_i;
  logic             ex_ready_i;
  logic [`XLEN-1:0] instr_rdata_i;
  logic [`XLEN-1:0] pc_id_i;
  rf_wr_t           wb_wr_i;
  rf_wr_t           ex_fw_i;
  logic             instr_req_o;
  logic             is_decoding_o;
  logic             id_ready_o;
  logic             id_valid_o;
  logic             illegal_insn_o;
  logic [`XLEN-1:0] jump_target_o;
  id_ex_t           id_ex_o;

  integer           seed;
  int               errors;
  int               checks;
  int               waited;
  int               kind;
  logic [`XLEN-1:0] cur_pc;
  logic [`XLEN-1:0] consumer;
  logic [`XLEN-1:0] shadow [`NUM_REGS];
  id_ex_t           held;
  expect_t          cur_exp;
  expect_t          exp_q [$];

  id_stage id_stage_inst
  (
    .clk            (clk),
    .rst_n          (rst_n),
    .fetch_enable_i (fetch_enable_i),
    .if_valid_i     (if_valid_i),
    .ex_ready_i     (ex_ready_i),
    .instr_rdata_i  (instr_rdata_i),
    .pc_id_i        (pc_id_i),
    .wb_wr_i        (wb_wr_i),
    .ex_fw_i        (ex_fw_i),
    .instr_req_o    (instr_req_o),
    .is_decoding_o  (is_decoding_o),
    .id_ready_o     (id_ready_o),
    .id_valid_o     (id_valid_o),
    .illegal_insn_o (illegal_insn_o),
    .jump_target_o  (jump_target_o),
    .id_ex_o        (id_ex_o)
  );

  // 100 ns period
  always #50 clk = ~clk;

  // Shadow of the register file, x0 never written
  always @(posedge clk)
  begin
    if (wb_wr_i.we && (wb_wr_i.waddr != 5'd0))
      shadow[wb_wr_i.waddr] <= wb_wr_i.wdata;
  end

  ////////////////////
  // Reference model
  ////////////////////
  // EX first, then WB, then register file
  function automatic logic [31:0] source_value(input logic [4:0] idx,
                                               input logic [31:0] regs [32],
                                               input rf_wr_t ex,
                                               input rf_wr_t wb);
    if (idx == 5'd0)
      return 32'd0;
    if (ex.we && (ex.waddr == idx))
      return ex.wdata;
    if (wb.we && (wb.waddr == idx))
      return wb.wdata;
    return regs[idx];
  endfunction

  function automatic id_ex_t ref_decode(input logic [31:0] instr,
                                        input logic [31:0] pc,
                                        input logic [31:0] regs [32],
                                        input rf_wr_t ex,
                                        input rf_wr_t wb,
                                        output logic [31:0] target,
                                        output logic legal);
    id_ex_t      e;
    logic [2:0]  f3;
    logic [31:0] a_val;
    logic [31:0] b_val;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_u;
    logic [31:0] imm_j;
    f3    = instr[14:12];
    a_val = source_value(instr[19:15], regs, ex, wb);
    b_val = source_value(instr[24:20], regs, ex, wb);
    imm_i = {{20{instr[31]}}, instr[31:20]};
    imm_s = {{20{instr[31]}}, instr[31:25], instr[11:7]};
    imm_b = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
    imm_u = {instr[31:12], 12'd0};
    imm_j = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
    // Defaults, an ADD that writes nothing
    e               = '0;
    e.alu_op        = ALU_ADD;
    e.jump          = JUMP_NONE;
    e.regfile_waddr = instr[11:7];
    e.data_type     = f3[1:0];
    e.data_sign_ext = !f3[2];
    e.operand_a     = a_val;
    legal           = 1'b1;
    target          = pc + imm_b;
    case (instr[6:0])
      OPC_LUI:
      begin
        e.operand_a  = 32'd0;
        e.operand_b  = imm_u;
        e.regfile_we = 1'b1;
      end
      OPC_AUIPC:
      begin
        e.operand_a  = pc;
        e.operand_b  = imm_u;
        e.regfile_we = 1'b1;
      end
      // Link address PC + 4
      OPC_JAL:
      begin
        e.operand_a  = pc;
        e.operand_b  = 32'd4;
        e.regfile_we = 1'b1;
        e.jump       = JUMP_JAL;
        target       = pc + imm_j;
      end
      OPC_BRANCH:
      begin
        e.operand_b = b_val;
        e.jump      = JUMP_BRANCH;
        case (f3)
          3'b000:  e.alu_op = ALU_EQ;
          3'b001:  e.alu_op = ALU_NE;
          3'b100:  e.alu_op = ALU_LT;
          3'b101:  e.alu_op = ALU_GE;
          3'b110:  e.alu_op = ALU_LTU;
          default: e.alu_op = ALU_GEU;
        endcase
      end
      OPC_LOAD:
      begin
        e.operand_b  = imm_i;
        e.regfile_we = 1'b1;
        e.data_req   = 1'b1;
      end
      OPC_STORE:
      begin
        e.operand_b = imm_s;
        e.data_req  = 1'b1;
        e.data_we   = 1'b1;
      end
      OPC_OP, OPC_OP_IMM:
      begin
        e.operand_b  = (instr[6:0] == OPC_OP) ? b_val : imm_i;
        e.regfile_we = 1'b1;
        case (f3)
          3'b000:  e.alu_op = (instr[6:0] == OPC_OP && instr[30]) ? ALU_SUB : ALU_ADD;
          3'b001:  e.alu_op = ALU_SLL;
          3'b010:  e.alu_op = ALU_SLT;
          3'b011:  e.alu_op = ALU_SLTU;
          3'b100:  e.alu_op = ALU_XOR;
          3'b101:  e.alu_op = instr[30] ? ALU_SRA : ALU_SRL;
          3'b110:  e.alu_op = ALU_OR;
          default: e.alu_op = ALU_AND;
        endcase
      end
      default:
        legal = 1'b0;
    endcase
    return e;
  endfunction

  ////////////////////
  // Stimulus helpers
  ////////////////////
  // Kinds 0 OP, 1 OP-IMM, 2 LUI, 3 AUIPC, 4 load, 5 store, 6 JAL, 7 branch
  function automatic logic [31:0] make_instr(input int sel);
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    r  = $random(seed);
    f3 = r[14:12];
    case (sel)
      0:
      begin
        f7 = ((f3 == 3'b000 || f3 == 3'b101) && r[30]) ? 7'h20 : 7'h00;
        return {f7, r[24:7], OPC_OP};
      end
      1:
      begin
        // Full immediates, shifts keep bit 30 only as SRAI
        if (f3 == 3'b001 || f3 == 3'b101)
          f7 = (f3 == 3'b101 && r[30]) ? 7'h20 : 7'h00;
        else
          f7 = r[31:25];
        return {f7, r[24:7], OPC_OP_IMM};
      end
      2: return {r[31:7], OPC_LUI};
      3: return {r[31:7], OPC_AUIPC};
      4:
      begin
        if (f3 == 3'b011 || f3[2:1] == 2'b11)
          f3 = 3'b010;
        return {r[31:15], f3, r[11:7], OPC_LOAD};
      end
      5:
      begin
        f3 = {1'b0, f3[1:0]};
        if (f3 == 3'b011)
          f3 = 3'b000;
        return {r[31:15], f3, r[11:7], OPC_STORE};
      end
      6: return {r[31:7], OPC_JAL};
      default:
      begin
        if (f3[2:1] == 2'b01)
          f3 = 3'b000;
        return {r[31:15], f3, r[11:7], OPC_BRANCH};
      end
    endcase
  endfunction

  task automatic compare_field(input string name, input logic [95:0] got,
                               input logic [95:0] exp);
    checks++;
    if (got !== exp)
    begin
      $display("ERROR %s: got 0x%0h, expected 0x%0h at %0t", name, got, exp, $time);
      errors++;
    end
  endtask

  task automatic abort_run(input string reason);
    $display("%s at %0t", reason, $time);
    $display("Checks: %0d, errors: %0d", checks, errors + 1);
    $display("Simulation failed");
    $finish;
  endtask

  task automatic write_reg(input logic [4:0] addr, input logic [31:0] data);
    wb_wr_i = {1'b1, addr, data};
    @(negedge clk);
    wb_wr_i.we = 1'b0;
  endtask

  // Present at a falling edge, hold until consumed, queue the expected bundle
  task automatic issue_instr(input logic [31:0] instr, output int stalls);
    expect_t     entry;
    logic [31:0] exp_target;
    logic        legal;
    instr_rdata_i = instr;
    pc_id_i       = cur_pc;
    if_valid_i    = 1'b1;
    stalls        = 0;
    #1;
    while (!id_valid_o && stalls < WAIT_LIMIT)
    begin
      @(negedge clk);
      #1;
      stalls++;
    end
    if (!id_valid_o)
      abort_run("Instruction was never consumed by the decode stage");
    else
    begin
      entry.bundle = ref_decode(instr, cur_pc, shadow, ex_fw_i, wb_wr_i, exp_target, legal);
      entry.full   = legal;
      compare_field("illegal_insn_o", illegal_insn_o, !legal);
      if (legal && entry.bundle.jump != JUMP_NONE)
        compare_field("jump_target_o", jump_target_o, exp_target);
      exp_q.push_back(entry);
    end
    @(negedge clk);
    if_valid_i = 1'b0;
    cur_pc     = cur_pc + 32'd4;
  endtask

  // Both forwarding ports driven for one instruction
  task automatic forward_case(input logic [31:0] instr, input rf_wr_t ex, input rf_wr_t wb);
    int stalls;
    ex_fw_i = ex;
    wb_wr_i = wb;
    issue_instr(instr, stalls);
    ex_fw_i.we = 1'b0;
    wb_wr_i.we = 1'b0;
  endtask

  ////////////////////
  // Compare process
  ////////////////////
  // One edge after consumption
  always
  begin
    @(posedge clk);
    #1;
    if (exp_q.size() != 0)
    begin
      cur_exp = exp_q.pop_front();
      compare_field("id_ex_o.regfile_we", id_ex_o.regfile_we, cur_exp.bundle.regfile_we);
      compare_field("id_ex_o.data_req", id_ex_o.data_req, cur_exp.bundle.data_req);
      compare_field("id_ex_o.jump", id_ex_o.jump, cur_exp.bundle.jump);
      if (cur_exp.full)
      begin
        compare_field("id_ex_o.alu_op", id_ex_o.alu_op, cur_exp.bundle.alu_op);
        compare_field("id_ex_o.operand_a", id_ex_o.operand_a, cur_exp.bundle.operand_a);
        compare_field("id_ex_o.operand_b", id_ex_o.operand_b, cur_exp.bundle.operand_b);
        compare_field("id_ex_o.regfile_waddr", id_ex_o.regfile_waddr,
                      cur_exp.bundle.regfile_waddr);
        compare_field("id_ex_o.data_we", id_ex_o.data_we, cur_exp.bundle.data_we);
        // Access size and extension matter for memory ops only
        if (cur_exp.bundle.data_req)
        begin
          compare_field("id_ex_o.data_type", id_ex_o.data_type, cur_exp.bundle.data_type);
          compare_field("id_ex_o.data_sign_ext", id_ex_o.data_sign_ext,
                        cur_exp.bundle.data_sign_ext);
        end
      end
    end
  end

  ////////////////////
  // Main sequence
  ////////////////////
  initial
  begin
    seed           = 73;
    errors         = 0;
    checks         = 0;
    cur_pc         = 32'h0000_1000;
    clk            = 1'b0;
    rst_n          = 1'b0;
    fetch_enable_i = 1'b0;
    if_valid_i     = 1'b0;
    ex_ready_i     = 1'b1;
    instr_rdata_i  = 32'h0000_0013;
    pc_id_i        = '0;
    wb_wr_i        = '0;
    ex_fw_i        = '0;
    for (int i = 0; i < `NUM_REGS; i++)
      shadow[i] = '0;

    repeat (2) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    // Idle after reset, empty ID/EX
    compare_field("instr_req_o", instr_req_o, 1'b0);
    compare_field("is_decoding_o", is_decoding_o, 1'b0);
    compare_field("id_ex_o.regfile_we", id_ex_o.regfile_we, 1'b0);
    compare_field("id_ex_o.alu_op", id_ex_o.alu_op, ALU_NOP);
    @(negedge clk);
    fetch_enable_i = 1'b1;
    @(posedge clk);
    #1;
    compare_field("instr_req_o", instr_req_o, 1'b1);
    compare_field("is_decoding_o", is_decoding_o, 1'b0);
    @(posedge clk);
    #1;
    compare_field("is_decoding_o", is_decoding_o, 1'b1);
    @(negedge clk);

    // Fill x1..x31 through WB
    for (int i = 1; i < `NUM_REGS; i++)
      write_reg(i[4:0], $random(seed));

    // Random decode, stalls behind loads allowed
    for (int n = 0; n < 40; n++)
    begin
      kind = $unsigned($random(seed)) % 6;
      issue_instr(make_instr(kind), waited);
    end

    // Forwarding priority on rs1 and rs2 of add x3, x7, x9
    consumer = {7'h00, 5'd9, 5'd7, 3'b000, 5'd3, OPC_OP};
    forward_case(consumer, {1'b1, 5'd7, 32'h1111_aaaa}, {1'b1, 5'd7, 32'h2222_bbbb});
    forward_case(consumer, {1'b1, 5'd9, 32'h3333_cccc}, {1'b1, 5'd9, 32'h4444_dddd});
    forward_case(consumer, {1'b0, 5'd7, 32'h5555_eeee}, {1'b1, 5'd7, 32'h6666_ffff});
    // x0 ignores both ports
    consumer = {7'h00, 5'd0, 5'd0, 3'b000, 5'd4, OPC_OP};
    forward_case(consumer, {1'b1, 5'd0, 32'h7777_0001}, {1'b1, 5'd0, 32'h8888_0002});

    // Load into x5, then add x6, x5, x1
    issue_instr({12'h010, 5'd2, 3'b010, 5'd5, OPC_LOAD}, waited);
    consumer      = {7'h00, 5'd1, 5'd5, 3'b000, 5'd6, OPC_OP};
    instr_rdata_i = consumer;
    pc_id_i       = cur_pc;
    if_valid_i    = 1'b1;
    #1;
    compare_field("id_ready_o", id_ready_o, 1'b0);
    @(posedge clk);
    #1;
    compare_field("id_ex_o.regfile_we", id_ex_o.regfile_we, 1'b0);
    compare_field("id_ex_o.data_req", id_ex_o.data_req, 1'b0);
    @(negedge clk);
    issue_instr(consumer, waited);
    compare_field("stall cycles", waited, 0);

    // Back-pressure holds every field
    issue_instr(make_instr(0), waited);
    ex_ready_i = 1'b0;
    #1;
    compare_field("id_ready_o", id_ready_o, 1'b0);
    held = id_ex_o;
    repeat (3)
    begin
      @(posedge clk);
      #1;
      compare_field("id_ex_o", id_ex_o, held);
    end
    @(negedge clk);
    ex_ready_i = 1'b1;
    @(posedge clk);
    #1;
    // Bubble keeps the payload
    compare_field("id_ex_o.regfile_we", id_ex_o.regfile_we, 1'b0);
    compare_field("id_ex_o.data_req", id_ex_o.data_req, 1'b0);
    compare_field("id_ex_o.data_we", id_ex_o.data_we, 1'b0);
    compare_field("id_ex_o.jump", id_ex_o.jump, JUMP_NONE);
    compare_field("id_ex_o.alu_op", id_ex_o.alu_op, held.alu_op);
    compare_field("id_ex_o.operand_a", id_ex_o.operand_a, held.operand_a);
    compare_field("id_ex_o.operand_b", id_ex_o.operand_b, held.operand_b);
    @(negedge clk);

    // Jumps and branches, then undefined opcodes
    for (int n = 0; n < 8; n++)
    begin
      issue_instr(make_instr(6), waited);
      issue_instr(make_instr(7), waited);
    end
    issue_instr((make_instr(2) & 32'hffff_ff80) | 32'h0000_000b, waited);
    issue_instr((make_instr(2) & 32'hffff_ff80) | 32'h0000_007f, waited);

    @(negedge clk);
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
      $display("Simulation completed successfully");
    else
      $display("Simulation failed");
    $finish;
  end

endmodule

//--- vlog.f
+incdir+verilog
verilog/id_pkg.sv
verilog/id_decoder.sv
verilog/id_controller.sv
verilog/id_register_file.sv
verilog/id_operand_path.sv
verilog/id_ex_pipe.sv
verilog/id_stage.sv
bench/id_stage_tb.sv

//--- Bender.yml
package:
  name: id_stage

export_include_dirs:
  - verilog

sources:
  - include_dirs:
      - verilog
    files:
      - verilog/id_pkg.sv
      - verilog/id_decoder.sv
      - verilog/id_controller.sv
      - verilog/id_register_file.sv
      - verilog/id_operand_path.sv
      - verilog/id_ex_pipe.sv
      - verilog/id_stage.sv
  - target: test
    include_dirs:
      - verilog
    files:
      - bench/id_stage_tb.sv
